// ==== src/udp_wrap_pkg.sv ====
package udp_wrap_pkg;

    // port dispatch sizes
    localparam int NUM_INBOUND = 5;
    localparam int NUM_LANES = 2;
    localparam int PAYLOAD_W = 64;
    localparam int KEEP_W = PAYLOAD_W / 8;

    // wishbone register space
    localparam int WB_ADR_W = 14;
    localparam int WB_DAT_W = 32;
    localparam int LANE_ADR_BIT = 2;
    localparam int STATS_ADR_BIT = 3;

    // index 0 takes 21616..21623 (read and write share the block)
    localparam logic [NUM_INBOUND-1:0][15:0] INBOUND_PORT = {
        16'd21608,
        16'd21601,
        16'd21603,
        16'd21614,
        16'd21618
    };

    // a set bit is left out of the compare
    localparam logic [NUM_INBOUND-1:0][15:0] INBOUND_MASK = {
        16'd0,
        16'd0,
        16'd0,
        16'd0,
        16'h0007
    };

    typedef enum logic [2:0] {
        PORT_RW   = 3'd0,
        PORT_NACK = 3'd1,
        PORT_CTRL = 3'd2,
        PORT_ACK  = 3'd3,
        PORT_HSK  = 3'd4,
        PORT_NONE = 3'd5
    } port_sel_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HDR,
        ST_DATA
    } route_state_e;

    typedef struct packed {
        logic [63:0] data;
        logic [15:0] dport;
    } udp_hdr_t;

    typedef struct packed {
        logic [PAYLOAD_W-1:0] data;
        logic [KEEP_W-1:0]    keep;
        logic                 last;
    } udp_beat_t;

    typedef struct packed {
        udp_hdr_t  hdr;
        port_sel_e port;
    } dec_hdr_t;

    typedef struct packed {
        logic        block_lock;
        logic        high_ber;
        logic [15:0] monitor;
    } lane_status_t;

    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [WB_ADR_W-1:0]   adr;
        logic [WB_DAT_W/8-1:0] sel;
        logic [WB_DAT_W-1:0]   dat;
    } wb_req_t;

endpackage

// ==== src/udp_port_decode.sv ====
module udp_port_decode import udp_wrap_pkg::*; (
    input  logic     wb_clk_i,
    input  logic     rst_i,

    // header stream from the udp core
    input  udp_hdr_t s_hdr_i,
    input  logic     s_hdr_valid_i,
    output logic     s_hdr_ready_o,

    // decoded header towards the router
    output dec_hdr_t dec_o,
    output logic     dec_valid_o,
    input  logic     dec_ready_i
);

    port_sel_e port_match;
    dec_hdr_t  slot;
    logic      slot_valid;
    logic      hdr_take;

    // scan from the top so that the lowest matching index wins
    always_comb begin
        port_match = PORT_NONE;
        for (int i = NUM_INBOUND - 1; i >= 0; i--) begin
            if (((s_hdr_i.dport ^ INBOUND_PORT[i]) & ~INBOUND_MASK[i]) == 16'd0) begin
                port_match = port_sel_e'(3'(i));
            end
        end
    end

    // slot can refill in the same cycle it is drained
    assign s_hdr_ready_o = !slot_valid || dec_ready_i;
    assign hdr_take = s_hdr_valid_i && s_hdr_ready_o;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            slot_valid <= 1'b0;
        end else if (s_hdr_ready_o) begin
            slot_valid <= s_hdr_valid_i;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (hdr_take) begin
            slot.hdr <= s_hdr_i;
            slot.port <= port_match;
        end
    end

    assign dec_o = slot;
    assign dec_valid_o = slot_valid;

endmodule

// ==== src/udp_stream_route.sv ====
module udp_stream_route import udp_wrap_pkg::*; (
    input  logic                          wb_clk_i,
    input  logic                          rst_i,

    // decoded header from the port decoder
    input  dec_hdr_t                      dec_i,
    input  logic                          dec_valid_i,
    output logic                          dec_ready_o,

    // payload beats from the udp core
    input  udp_beat_t                     s_data_i,
    input  logic                          s_data_valid_i,
    output logic                          s_data_ready_o,

    // per-port header outputs
    output udp_hdr_t [NUM_INBOUND-1:0]    m_hdr_o,
    output logic [NUM_INBOUND-1:0]        m_hdr_valid_o,
    input  logic [NUM_INBOUND-1:0]        m_hdr_ready_i,

    // shared payload bus, one valid per port
    output udp_beat_t                     m_data_o,
    output logic [NUM_INBOUND-1:0]        m_data_valid_o,
    input  logic [NUM_INBOUND-1:0]        m_data_ready_i,

    output logic [15:0]                   routed_cnt_o,
    output logic [15:0]                   dropped_cnt_o
);

    route_state_e           state;
    udp_hdr_t               hdr_q;
    port_sel_e              port_q;
    logic                   drop;
    logic [NUM_INBOUND-1:0] port_oh;
    logic                   hdr_done;
    logic                   beat_done;
    logic [15:0]            routed_cnt;
    logic [15:0]            dropped_cnt;

    assign drop = (port_q == PORT_NONE);
    assign port_oh = drop ? '0 : (NUM_INBOUND'(1) << port_q);

    assign dec_ready_o = (state == ST_IDLE);

    // header is replayed to every port, only one valid is raised
    always_comb begin
        for (int i = 0; i < NUM_INBOUND; i++) begin
            m_hdr_o[i] = hdr_q;
        end
    end
    assign m_hdr_valid_o = (state == ST_HDR) ? port_oh : '0;
    assign hdr_done = (state == ST_HDR) && |(m_hdr_ready_i & port_oh);

    // payload passes straight through while streaming
    assign m_data_o = s_data_i;
    assign m_data_valid_o = (state == ST_DATA && s_data_valid_i) ? port_oh : '0;
    always_comb begin
        s_data_ready_o = 1'b0;
        if (state == ST_DATA) begin
            // discarded packets are swallowed at full rate
            s_data_ready_o = drop ? 1'b1 : |(m_data_ready_i & port_oh);
        end
    end
    assign beat_done = s_data_valid_i && s_data_ready_o && s_data_i.last;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            state <= ST_IDLE;
            port_q <= PORT_NONE;
            routed_cnt <= 16'd0;
            dropped_cnt <= 16'd0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (dec_valid_i) begin
                        port_q <= dec_i.port;
                        if (dec_i.port == PORT_NONE) begin
                            state <= ST_DATA;
                            dropped_cnt <= dropped_cnt + 16'd1;
                        end else begin
                            state <= ST_HDR;
                        end
                    end
                end
                ST_HDR: begin
                    if (hdr_done) begin
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (beat_done) begin
                        state <= ST_IDLE;
                        if (!drop) begin
                            routed_cnt <= routed_cnt + 16'd1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (state == ST_IDLE && dec_valid_i) begin
            hdr_q <= dec_i.hdr;
        end
    end

    assign routed_cnt_o = routed_cnt;
    assign dropped_cnt_o = dropped_cnt;

endmodule

// ==== src/link_ctrl_regs.sv ====
module link_ctrl_regs import udp_wrap_pkg::*; (
    input  logic                           wb_clk_i,
    input  logic                           rst_i,

    // wishbone slave
    input  wb_req_t                        wb_req_i,
    output logic                           wb_ack_o,
    output logic [WB_DAT_W-1:0]            wb_dat_o,

    // transceiver status
    input  logic                           qpll_lock_i,
    input  lane_status_t [NUM_LANES-1:0]   lane_status_i,

    // router statistics
    input  logic [15:0]                    routed_cnt_i,
    input  logic [15:0]                    dropped_cnt_i,

    // transceiver controls
    output logic                           link_rst_o,
    output logic [NUM_LANES-1:0]           eye_rst_o,
    output logic [NUM_LANES*3-1:0]         loopback_o
);

    logic                                  ack_q;
    logic                                  wb_access;
    logic                                  wr_en;
    logic                                  lane_sel;
    logic                                  link_rst_q;
    logic [NUM_LANES-1:0]                  eye_rst_q;
    logic [NUM_LANES-1:0][2:0]             loopback_q;
    logic [NUM_LANES-1:0][WB_DAT_W-1:0]    status_word;
    logic [WB_DAT_W-1:0]                   stats_word;

    // one ack per access, a held strobe waits for ack to drop
    assign wb_access = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    assign wr_en = wb_access && wb_req_i.we && !wb_req_i.adr[STATS_ADR_BIT];
    assign lane_sel = wb_req_i.adr[LANE_ADR_BIT];

    // per-lane status words, shared bits repeat in both
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            status_word[l] = '0;
            status_word[l][0] = link_rst_q;
            status_word[l][1] = qpll_lock_i;
            status_word[l][2] = lane_status_i[l].block_lock;
            status_word[l][3] = lane_status_i[l].high_ber;
            status_word[l][4] = eye_rst_q[l];
            status_word[l][10:8] = loopback_q[l];
            status_word[l][31:16] = lane_status_i[l].monitor;
        end
    end

    assign stats_word = {routed_cnt_i, dropped_cnt_i};

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
            link_rst_q <= 1'b0;
            eye_rst_q <= '0;
            loopback_q <= '0;
        end else begin
            ack_q <= wb_access;
            if (wr_en && wb_req_i.sel[0]) begin
                link_rst_q <= wb_req_i.dat[0];
                eye_rst_q[lane_sel] <= wb_req_i.dat[4];
            end
            if (wr_en && wb_req_i.sel[1]) begin
                loopback_q[lane_sel] <= wb_req_i.dat[10:8];
            end
        end
    end

    // read data is captured on the access edge and shown with ack
    always_ff @(posedge wb_clk_i) begin
        if (wb_access && !wb_req_i.we) begin
            if (wb_req_i.adr[STATS_ADR_BIT]) begin
                wb_dat_o <= stats_word;
            end else begin
                wb_dat_o <= status_word[lane_sel];
            end
        end
    end

    assign wb_ack_o = ack_q;
    assign link_rst_o = link_rst_q;
    assign eye_rst_o = eye_rst_q;
    assign loopback_o = loopback_q;

endmodule

// ==== src/udp_wrap_top.sv ====
module udp_wrap_top import udp_wrap_pkg::*; (
    input  logic                          wb_clk_i,
    input  logic                          rst_i,

    // inbound udp header and payload
    input  udp_hdr_t                      s_hdr_i,
    input  logic                          s_hdr_valid_i,
    output logic                          s_hdr_ready_o,
    input  udp_beat_t                     s_data_i,
    input  logic                          s_data_valid_i,
    output logic                          s_data_ready_o,

    // dispatched ports
    output udp_hdr_t [NUM_INBOUND-1:0]    m_hdr_o,
    output logic [NUM_INBOUND-1:0]        m_hdr_valid_o,
    input  logic [NUM_INBOUND-1:0]        m_hdr_ready_i,
    output udp_beat_t                     m_data_o,
    output logic [NUM_INBOUND-1:0]        m_data_valid_o,
    input  logic [NUM_INBOUND-1:0]        m_data_ready_i,

    // transceiver register block
    input  wb_req_t                       wb_req_i,
    output logic                          wb_ack_o,
    output logic [WB_DAT_W-1:0]           wb_dat_o,
    input  logic                          qpll_lock_i,
    input  lane_status_t [NUM_LANES-1:0]  lane_status_i,
    output logic                          link_rst_o,
    output logic [NUM_LANES-1:0]          eye_rst_o,
    output logic [NUM_LANES*3-1:0]        loopback_o
);

    dec_hdr_t    dec;
    logic        dec_valid;
    logic        dec_ready;
    logic [15:0] routed_cnt;
    logic [15:0] dropped_cnt;

    udp_port_decode u_decode (
        .wb_clk_i      (wb_clk_i),
        .rst_i         (rst_i),
        .s_hdr_i       (s_hdr_i),
        .s_hdr_valid_i (s_hdr_valid_i),
        .s_hdr_ready_o (s_hdr_ready_o),
        .dec_o         (dec),
        .dec_valid_o   (dec_valid),
        .dec_ready_i   (dec_ready)
    );

    udp_stream_route u_route (
        .wb_clk_i       (wb_clk_i),
        .rst_i          (rst_i),
        .dec_i          (dec),
        .dec_valid_i    (dec_valid),
        .dec_ready_o    (dec_ready),
        .s_data_i       (s_data_i),
        .s_data_valid_i (s_data_valid_i),
        .s_data_ready_o (s_data_ready_o),
        .m_hdr_o        (m_hdr_o),
        .m_hdr_valid_o  (m_hdr_valid_o),
        .m_hdr_ready_i  (m_hdr_ready_i),
        .m_data_o       (m_data_o),
        .m_data_valid_o (m_data_valid_o),
        .m_data_ready_i (m_data_ready_i),
        .routed_cnt_o   (routed_cnt),
        .dropped_cnt_o  (dropped_cnt)
    );

    link_ctrl_regs u_regs (
        .wb_clk_i      (wb_clk_i),
        .rst_i         (rst_i),
        .wb_req_i      (wb_req_i),
        .wb_ack_o      (wb_ack_o),
        .wb_dat_o      (wb_dat_o),
        .qpll_lock_i   (qpll_lock_i),
        .lane_status_i (lane_status_i),
        .routed_cnt_i  (routed_cnt),
        .dropped_cnt_i (dropped_cnt),
        .link_rst_o    (link_rst_o),
        .eye_rst_o     (eye_rst_o),
        .loopback_o    (loopback_o)
    );

endmodule

// ==== test/tb_udp_wrap.sv ====
module tb_udp_wrap import udp_wrap_pkg::*; ();

    localparam int TIMEOUT = 1000;

    typedef struct packed {
        logic [2:0] port;
        udp_hdr_t   hdr;
    } exp_hdr_t;

    typedef struct packed {
        logic [2:0] port;
        udp_beat_t  beat;
    } exp_beat_t;

    logic                          wb_clk_i;
    logic                          rst_i;
    udp_hdr_t                      s_hdr_i;
    logic                          s_hdr_valid_i;
    logic                          s_hdr_ready_o;
    udp_beat_t                     s_data_i;
    logic                          s_data_valid_i;
    logic                          s_data_ready_o;
    udp_hdr_t [NUM_INBOUND-1:0]    m_hdr_o;
    logic [NUM_INBOUND-1:0]        m_hdr_valid_o;
    logic [NUM_INBOUND-1:0]        m_hdr_ready_i;
    udp_beat_t                     m_data_o;
    logic [NUM_INBOUND-1:0]        m_data_valid_o;
    logic [NUM_INBOUND-1:0]        m_data_ready_i;
    wb_req_t                       wb_req_i;
    logic                          wb_ack_o;
    logic [WB_DAT_W-1:0]           wb_dat_o;
    logic                          qpll_lock_i;
    lane_status_t [NUM_LANES-1:0]  lane_status_i;
    logic                          link_rst_o;
    logic [NUM_LANES-1:0]          eye_rst_o;
    logic [NUM_LANES*3-1:0]        loopback_o;

    logic [31:0]                   rng;
    logic [31:0]                   ready_rng;
    logic                          ready_rand_en;
    udp_hdr_t                      hdr_q[$];
    udp_beat_t                     beat_q[$];
    exp_hdr_t                      exp_hdr[$];
    exp_beat_t                     exp_beat[$];
    int                            routed_exp;
    int                            dropped_exp;
    logic                          link_m;
    logic [1:0]                    eye_m;
    logic [1:0][2:0]               lb_m;
    logic [20:0]                   quiet_outs;

    udp_wrap_top uut (.*);

    assign quiet_outs = {m_hdr_valid_o, m_data_valid_o, s_data_ready_o, wb_ack_o,
                         link_rst_o, eye_rst_o, loopback_o};

    initial wb_clk_i = 1'b0;
    always #5 wb_clk_i = ~wb_clk_i;

    task automatic abort_run(input string why);
        $display("ERROR at time %0t: %s", $time, why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] expected,
                                   input logic [127:0] actual);
        $display("FAILED at time %0t: %s expected %0h got %0h", $time, name, expected, actual);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // 21616..21623 share index 0, unlisted ports are dropped
    function automatic logic [2:0] expected_port(input logic [15:0] dport);
        if (dport >= 16'd21616 && dport <= 16'd21623) return 3'd0;
        case (dport)
            16'd21614: return 3'd1;
            16'd21603: return 3'd2;
            16'd21601: return 3'd3;
            16'd21608: return 3'd4;
            default:   return 3'd5;
        endcase
    endfunction

    function automatic logic [13:0] reg_addr(input logic stats, input logic lane);
        return {10'd0, stats, lane, 2'd0};
    endfunction

    function automatic logic [31:0] status_model(input logic lane);
        logic [31:0] w;
        w = '0;
        w[0] = link_m;
        w[1] = qpll_lock_i;
        w[2] = lane_status_i[lane].block_lock;
        w[3] = lane_status_i[lane].high_ber;
        w[4] = eye_m[lane];
        w[10:8] = lb_m[lane];
        w[31:16] = lane_status_i[lane].monitor;
        return w;
    endfunction

    task automatic add_packet(input logic [15:0] dport, input int len);
        udp_hdr_t    h;
        udp_beat_t   b;
        exp_hdr_t    eh;
        exp_beat_t   eb;
        logic [31:0] r;
        h.data = {next_rand(), next_rand()};
        h.dport = dport;
        hdr_q.push_back(h);
        eh.port = expected_port(dport);
        eh.hdr = h;
        if (eh.port == 3'd5) dropped_exp++;
        else begin
            routed_exp++;
            exp_hdr.push_back(eh);
        end
        for (int i = 0; i < len; i++) begin
            r = next_rand();
            b.data = {next_rand(), next_rand()};
            b.keep = r[7:0];
            b.last = (i == len - 1);
            beat_q.push_back(b);
            eb.port = eh.port;
            eb.beat = b;
            if (eh.port != 3'd5) exp_beat.push_back(eb);
        end
    endtask

    task automatic send_headers();
        int n;
        while (hdr_q.size() > 0) begin
            @(negedge wb_clk_i);
            s_hdr_valid_i = 1'b0;
            if (next_rand() % 32'd4 == 32'd0) @(negedge wb_clk_i);
            s_hdr_i = hdr_q.pop_front();
            s_hdr_valid_i = 1'b1;
            n = 0;
            do begin
                @(posedge wb_clk_i);
                n++;
                if (n > TIMEOUT) abort_run("header input was never accepted");
            end while (!s_hdr_ready_o);
        end
        @(negedge wb_clk_i);
        s_hdr_valid_i = 1'b0;
    endtask

    task automatic send_beats();
        int n;
        while (beat_q.size() > 0) begin
            @(negedge wb_clk_i);
            s_data_valid_i = 1'b0;
            if (next_rand() % 32'd5 == 32'd0) @(negedge wb_clk_i);
            s_data_i = beat_q.pop_front();
            s_data_valid_i = 1'b1;
            n = 0;
            do begin
                @(posedge wb_clk_i);
                n++;
                if (n > TIMEOUT) abort_run("payload beat was never accepted");
            end while (!s_data_ready_o);
        end
        @(negedge wb_clk_i);
        s_data_valid_i = 1'b0;
    endtask

    task automatic wb_cycle(input logic we, input logic [13:0] adr, input logic [3:0] sel,
                            input logic [31:0] dat, output logic [31:0] rdat);
        int n;
        @(negedge wb_clk_i);
        wb_req_i = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: dat};
        n = 0;
        do begin
            @(posedge wb_clk_i);
            n++;
            if (n > TIMEOUT) abort_run("wishbone ack never arrived");
        end while (!wb_ack_o);
        rdat = wb_dat_o;
        @(negedge wb_clk_i);
        wb_req_i = '0;
        @(posedge wb_clk_i);
        assert (!wb_ack_o) else abort_run("wishbone ack stayed high for a second cycle");
    endtask

    task automatic drive_status();
        logic [31:0] r0;
        logic [31:0] r1;
        r0 = next_rand();
        r1 = next_rand();
        @(negedge wb_clk_i);
        qpll_lock_i = r0[31];
        lane_status_i = {r1[17:0], r0[17:0]};
    endtask

    // every status input bit flips so that each one is read back at both levels
    task automatic invert_status();
        @(negedge wb_clk_i);
        qpll_lock_i = ~qpll_lock_i;
        lane_status_i = ~lane_status_i;
    endtask

    task automatic check_status(input logic lane);
        logic [31:0] rd;
        wb_cycle(1'b0, reg_addr(1'b0, lane), 4'hf, 32'd0, rd);
        assert (rd == status_model(lane))
            else report_mismatch("wb_dat_o status word", 128'(status_model(lane)), 128'(rd));
    endtask

    task automatic check_stats();
        logic [31:0] rd;
        wb_cycle(1'b0, reg_addr(1'b1, 1'b0), 4'hf, 32'd0, rd);
        assert (rd == {16'(routed_exp), 16'(dropped_exp)})
            else report_mismatch("wb_dat_o statistics word",
                                 128'({16'(routed_exp), 16'(dropped_exp)}), 128'(rd));
    endtask

    task automatic write_ctrl(input logic lane, input logic [3:0] sel, input logic [31:0] dat);
        logic [31:0] rd;
        if (sel[0]) begin
            link_m = dat[0];
            eye_m[lane] = dat[4];
        end
        if (sel[1]) lb_m[lane] = dat[10:8];
        wb_cycle(1'b1, reg_addr(1'b0, lane), sel, dat, rd);
        assert ({link_rst_o, eye_rst_o, loopback_o} == {link_m, eye_m, lb_m})
            else report_mismatch("link_rst_o, eye_rst_o, loopback_o",
                                 128'({link_m, eye_m, lb_m}),
                                 128'({link_rst_o, eye_rst_o, loopback_o}));
    endtask

    // random per-port back-pressure, ready about three cycles in four
    always @(negedge wb_clk_i) begin
        if (ready_rand_en) begin
            ready_rng = xorshift(ready_rng);
            m_hdr_ready_i = ready_rng[4:0] | ready_rng[9:5];
            m_data_ready_i = ready_rng[14:10] | ready_rng[19:15];
        end
    end

    // output side of the reference model, one entry per transfer
    always @(posedge wb_clk_i) begin
        exp_hdr_t  eh;
        exp_beat_t eb;
        if (!rst_i) begin
            for (int i = 0; i < NUM_INBOUND; i++) begin
                if (m_hdr_valid_o[i] && m_hdr_ready_i[i]) begin
                    assert (exp_hdr.size() > 0) else abort_run("header sent for a dropped packet");
                    eh = exp_hdr.pop_front();
                    assert (eh.port == 3'(i))
                        else report_mismatch("m_hdr_valid_o index", 128'(eh.port), 128'(i));
                    assert (m_hdr_o[i] == eh.hdr)
                        else report_mismatch("m_hdr_o", 128'(eh.hdr), 128'(m_hdr_o[i]));
                end
                if (m_data_valid_o[i] && m_data_ready_i[i]) begin
                    assert (exp_beat.size() > 0) else abort_run("payload beat with none expected");
                    eb = exp_beat.pop_front();
                    assert (eb.port == 3'(i))
                        else report_mismatch("m_data_valid_o index", 128'(eb.port), 128'(i));
                    assert (m_data_o == eb.beat)
                        else report_mismatch("m_data_o", 128'(eb.beat), 128'(m_data_o));
                end
            end
        end
    end

    assert property (@(posedge wb_clk_i) disable iff (rst_i) $onehot0(m_hdr_valid_o))
        else abort_run("more than one header valid was high");
    assert property (@(posedge wb_clk_i) disable iff (rst_i) $onehot0(m_data_valid_o))
        else abort_run("more than one payload valid was high");
    assert property (@(posedge wb_clk_i) disable iff (rst_i)
        (|(m_hdr_valid_o & ~m_hdr_ready_i)) |=> ($stable(m_hdr_valid_o) && $stable(m_hdr_o)))
        else abort_run("a stalled output header changed before it was taken");

    initial begin
        int n;
        rng = 32'd70066;
        rst_i = 1'b1;
        s_hdr_i = '0;
        s_hdr_valid_i = 1'b0;
        s_data_i = '0;
        s_data_valid_i = 1'b0;
        m_hdr_ready_i = '1;
        m_data_ready_i = '1;
        wb_req_i = '0;
        qpll_lock_i = 1'b0;
        lane_status_i = '0;
        ready_rand_en = 1'b0;
        ready_rng = next_rand();
        link_m = 1'b0;
        eye_m = '0;
        lb_m = '0;
        routed_exp = 0;
        dropped_exp = 0;
        repeat (2) @(posedge wb_clk_i);
        @(negedge wb_clk_i);
        rst_i = 1'b0;
        @(posedge wb_clk_i);
        assert (quiet_outs == '0)
            else report_mismatch("valid, ack and control outputs", 128'(0), 128'(quiet_outs));
        assert (s_hdr_ready_o) else report_mismatch("s_hdr_ready_o", 128'(1), 128'(0));
        drive_status();
        check_status(1'b0);
        check_status(1'b1);
        check_stats();

        // every listed port once, the whole masked range, two misses, then random traffic
        add_packet(16'd21618, 2);
        add_packet(16'd21614, 1);
        add_packet(16'd21603, 3);
        add_packet(16'd21601, 2);
        add_packet(16'd21608, 1);
        for (int p = 21616; p <= 21623; p++) add_packet(16'(p), 2);
        add_packet(16'd21552, 3);
        add_packet(16'd21624, 2);
        for (int k = 0; k < 40; k++) begin
            add_packet(16'd21596 + 16'(next_rand() % 32'd32), 1 + int'(next_rand() % 32'd6));
        end
        ready_rand_en = 1'b1;
        fork
            send_headers();
            send_beats();
        join
        n = 0;
        while (exp_hdr.size() > 0 || exp_beat.size() > 0) begin
            @(negedge wb_clk_i);
            n++;
            if (n > TIMEOUT) abort_run("routed packets did not all reach their ports");
        end
        ready_rand_en = 1'b0;
        check_stats();

        write_ctrl(1'b0, 4'b0011, 32'h0000_0511);
        write_ctrl(1'b1, 4'b0011, 32'h0000_0210);
        // select byte 1 clear, loopback must hold
        write_ctrl(1'b0, 4'b0001, 32'h0000_0701);
        write_ctrl(1'b1, 4'b0010, 32'h0000_0600);
        drive_status();
        check_status(1'b0);
        check_status(1'b1);
        drive_status();
        check_status(1'b1);
        check_status(1'b0);
        invert_status();
        check_status(1'b0);
        check_status(1'b1);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== filelist.f ====
src/udp_wrap_pkg.sv
src/udp_port_decode.sv
src/udp_stream_route.sv
src/link_ctrl_regs.sv
src/udp_wrap_top.sv
test/tb_udp_wrap.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing
TOP       ?= tb_udp_wrap
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= *** PASSED ***

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -F '$(PASS_MSG)' > /dev/null

clean:
	rm -rf $(OBJ_DIR)
